// ==== rtl/sched_pkg.sv ====
package sched_pkg;

    // macro instruction widths, one per unit
    localparam int MIW_MVU  = 40;
    localparam int MIW_EVRF = 32;
    localparam int MIW_MFU  = 36;
    localparam int MIW_LD   = 44;

    // full chain word: mvu, evrf, two mfus, ld
    localparam int MICW = MIW_MVU + MIW_EVRF + 2 * MIW_MFU + MIW_LD;

    // tag sits in the low bits of the mvu instruction
    localparam int NTAGW = 5;

    // one output channel per unit
    localparam int NUM_UNITS = 5;

    // positions in the write-ready vector
    localparam int UNIT_MVU  = 0;
    localparam int UNIT_EVRF = 1;
    localparam int UNIT_MFU0 = 2;
    localparam int UNIT_MFU1 = 3;
    localparam int UNIT_LD   = 4;

    // defaults, overridden from the top level
    localparam int INST_DEPTH_DEFAULT = 256;
    localparam int QDEPTH_DEFAULT     = 4;

    // per-unit macro instructions
    typedef logic [MIW_MVU-1:0]  mvu_minst_t;
    typedef logic [MIW_EVRF-1:0] evrf_minst_t;
    typedef logic [MIW_MFU-1:0]  mfu_minst_t;
    typedef logic [MIW_LD-1:0]   ld_minst_t;

    typedef logic [NTAGW-1:0] mvu_tag_t;

    // an mvu tag of all ones ends a chain
    localparam mvu_tag_t HALT_TAG = '1;

    // first member is the msb end, so mvu lands at bit 0
    typedef struct packed {
        ld_minst_t   ld;
        mfu_minst_t  mfu1;
        mfu_minst_t  mfu0;
        evrf_minst_t evrf;
        mvu_minst_t  mvu;
    } minst_chain_t;

endpackage

// ==== rtl/minst_chain_ram.sv ====
module minst_chain_ram #(
    parameter int INST_DEPTH = sched_pkg::INST_DEPTH_DEFAULT,
    localparam int ADDRW = $clog2(INST_DEPTH)
) (
    input  logic                    clk,
    input  logic                    i_wr_en,
    input  logic [ADDRW-1:0]        i_wr_addr,
    input  sched_pkg::minst_chain_t i_wr_data,
    input  logic [ADDRW-1:0]        i_rd_addr,
    output sched_pkg::minst_chain_t o_rd_data
);

    logic [sched_pkg::MICW-1:0] mem [INST_DEPTH];

    // host write port
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // registered read, data one cycle after address
    always_ff @(posedge clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// ==== rtl/minst_fifo.sv ====
module minst_fifo #(
    parameter int QDEPTH = sched_pkg::QDEPTH_DEFAULT,
    parameter type payload_t = logic [7:0],
    localparam int PTRW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1,
    localparam int CNTW = $clog2(QDEPTH + 1)
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_wr_valid,
    output logic     o_wr_ready,
    input  payload_t i_wr_data,
    output logic     o_rd_valid,
    input  logic     i_rd_ready,
    output payload_t o_rd_data
);

    localparam logic [PTRW-1:0] LAST_SLOT = PTRW'(QDEPTH - 1);
    localparam logic [CNTW-1:0] FULL_CNT  = CNTW'(QDEPTH);

    payload_t        buffer [QDEPTH];
    logic [PTRW-1:0] wr_ptr;
    logic [PTRW-1:0] rd_ptr;
    logic [CNTW-1:0] count;
    logic            full;
    logic            empty;
    logic            do_push;
    logic            do_pop;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);

    assign o_wr_ready = !full;
    assign o_rd_valid = !empty;
    assign o_rd_data  = buffer[rd_ptr];

    assign do_pop  = i_rd_ready && !empty;
    // a pop in the same cycle frees the slot of a full queue
    assign do_push = i_wr_valid && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/chain_issue_ctrl.sv ====
module chain_issue_ctrl #(
    parameter int INST_DEPTH = sched_pkg::INST_DEPTH_DEFAULT,
    localparam int ADDRW = $clog2(INST_DEPTH)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_start,
    input  logic [ADDRW-1:0]               i_pc_start,
    input  sched_pkg::minst_chain_t        i_inst,
    input  logic [sched_pkg::NUM_UNITS-1:0] i_fifo_ready,
    output logic [ADDRW-1:0]               o_rd_addr,
    output logic                           o_issue,
    output logic                           o_busy
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_t;

    state_t              state;
    state_t              state_nxt;
    logic [ADDRW-1:0]    pc;
    logic [ADDRW-1:0]    pc_nxt;
    logic                presented;
    sched_pkg::mvu_tag_t tag;
    logic                running;
    logic                tag_halt;
    logic                halt;
    logic                all_ready;

    assign running = (state == ST_RUN);

    // halt check on the word the ram is showing
    assign tag      = i_inst.mvu[sched_pkg::NTAGW-1:0];
    assign tag_halt = (tag == sched_pkg::HALT_TAG);
    assign halt     = running && presented && tag_halt;

    // all five queues must take the word together
    assign all_ready = &i_fifo_ready;
    assign o_issue   = running && presented && !tag_halt && all_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (i_start) begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                if (halt) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_comb begin
        pc_nxt = pc;
        if (!running && i_start) begin
            pc_nxt = i_pc_start;
        end else if (o_issue) begin
            pc_nxt = pc + 1'b1;
        end
    end

    // read ahead with the next pc, so the ram output tracks pc exactly
    assign o_rd_addr = pc_nxt;
    assign o_busy    = running;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            pc        <= '0;
            presented <= 1'b0;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
            // first word shows one cycle after the start edge
            presented <= running && !halt;
        end
    end

endmodule

// ==== rtl/top_sched.sv ====
module top_sched #(
    parameter int INST_DEPTH = sched_pkg::INST_DEPTH_DEFAULT,
    parameter int QDEPTH     = sched_pkg::QDEPTH_DEFAULT,
    localparam int ADDRW = $clog2(INST_DEPTH)
) (
    input  logic                    clk,
    input  logic                    rst,
    // host write port
    input  logic                    i_minst_wr_en,
    input  logic [ADDRW-1:0]        i_minst_wr_addr,
    input  sched_pkg::minst_chain_t i_minst_wr_data,
    // run control
    input  logic                    i_start,
    input  logic [ADDRW-1:0]        i_pc_start,
    output logic                    o_busy,
    // unit channels
    output logic                    o_mvu_minst_valid,
    input  logic                    i_mvu_minst_ready,
    output sched_pkg::mvu_minst_t   o_mvu_minst,
    output logic                    o_evrf_minst_valid,
    input  logic                    i_evrf_minst_ready,
    output sched_pkg::evrf_minst_t  o_evrf_minst,
    output logic                    o_mfu0_minst_valid,
    input  logic                    i_mfu0_minst_ready,
    output sched_pkg::mfu_minst_t   o_mfu0_minst,
    output logic                    o_mfu1_minst_valid,
    input  logic                    i_mfu1_minst_ready,
    output sched_pkg::mfu_minst_t   o_mfu1_minst,
    output logic                    o_ld_minst_valid,
    input  logic                    i_ld_minst_ready,
    output sched_pkg::ld_minst_t    o_ld_minst
);

    logic [ADDRW-1:0]                rd_addr;
    sched_pkg::minst_chain_t         inst;
    logic [sched_pkg::NUM_UNITS-1:0] fifo_ready;
    logic                            issue;

    minst_chain_ram #(
        .INST_DEPTH (INST_DEPTH)
    ) u_chain_ram (
        .clk       (clk),
        .i_wr_en   (i_minst_wr_en),
        .i_wr_addr (i_minst_wr_addr),
        .i_wr_data (i_minst_wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (inst)
    );

    chain_issue_ctrl #(
        .INST_DEPTH (INST_DEPTH)
    ) u_issue_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_start      (i_start),
        .i_pc_start   (i_pc_start),
        .i_inst       (inst),
        .i_fifo_ready (fifo_ready),
        .o_rd_addr    (rd_addr),
        .o_issue      (issue),
        .o_busy       (o_busy)
    );

    // one queue per unit, all pushed by the same strobe
    minst_fifo #(
        .QDEPTH    (QDEPTH),
        .payload_t (sched_pkg::mvu_minst_t)
    ) u_mvu_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_wr_valid (issue),
        .o_wr_ready (fifo_ready[sched_pkg::UNIT_MVU]),
        .i_wr_data  (inst.mvu),
        .o_rd_valid (o_mvu_minst_valid),
        .i_rd_ready (i_mvu_minst_ready),
        .o_rd_data  (o_mvu_minst)
    );

    minst_fifo #(
        .QDEPTH    (QDEPTH),
        .payload_t (sched_pkg::evrf_minst_t)
    ) u_evrf_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_wr_valid (issue),
        .o_wr_ready (fifo_ready[sched_pkg::UNIT_EVRF]),
        .i_wr_data  (inst.evrf),
        .o_rd_valid (o_evrf_minst_valid),
        .i_rd_ready (i_evrf_minst_ready),
        .o_rd_data  (o_evrf_minst)
    );

    minst_fifo #(
        .QDEPTH    (QDEPTH),
        .payload_t (sched_pkg::mfu_minst_t)
    ) u_mfu0_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_wr_valid (issue),
        .o_wr_ready (fifo_ready[sched_pkg::UNIT_MFU0]),
        .i_wr_data  (inst.mfu0),
        .o_rd_valid (o_mfu0_minst_valid),
        .i_rd_ready (i_mfu0_minst_ready),
        .o_rd_data  (o_mfu0_minst)
    );

    minst_fifo #(
        .QDEPTH    (QDEPTH),
        .payload_t (sched_pkg::mfu_minst_t)
    ) u_mfu1_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_wr_valid (issue),
        .o_wr_ready (fifo_ready[sched_pkg::UNIT_MFU1]),
        .i_wr_data  (inst.mfu1),
        .o_rd_valid (o_mfu1_minst_valid),
        .i_rd_ready (i_mfu1_minst_ready),
        .o_rd_data  (o_mfu1_minst)
    );

    minst_fifo #(
        .QDEPTH    (QDEPTH),
        .payload_t (sched_pkg::ld_minst_t)
    ) u_ld_fifo (
        .clk        (clk),
        .rst        (rst),
        .i_wr_valid (issue),
        .o_wr_ready (fifo_ready[sched_pkg::UNIT_LD]),
        .i_wr_data  (inst.ld),
        .o_rd_valid (o_ld_minst_valid),
        .i_rd_ready (i_ld_minst_ready),
        .o_rd_data  (o_ld_minst)
    );

endmodule

// ==== verification/tb_top_sched.sv ====
module tb_top_sched;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int INST_DEPTH = 256;
    localparam int QDEPTH     = 4;
    localparam int ADDRW      = $clog2(INST_DEPTH);
    localparam int NUM_UNITS  = sched_pkg::NUM_UNITS;
    localparam int SEED       = 32'he4dd_5384;

    // words issued over all runs size the watchdog
    localparam int TOTAL_WORDS     = 20 + 40 + 10 + 8 + 4;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 2000;

    logic                    clk;
    logic                    rst;
    logic                    minst_wr_en;
    logic [ADDRW-1:0]        minst_wr_addr;
    sched_pkg::minst_chain_t minst_wr_data;
    logic                    start_pulse;
    logic [ADDRW-1:0]        pc_start;
    logic                    busy;
    logic [NUM_UNITS-1:0]    rdy;
    logic [NUM_UNITS-1:0]    vld;
    logic [63:0]             chan_data [NUM_UNITS];

    logic                   mvu_valid;
    logic                   evrf_valid;
    logic                   mfu0_valid;
    logic                   mfu1_valid;
    logic                   ld_valid;
    sched_pkg::mvu_minst_t  mvu_minst;
    sched_pkg::evrf_minst_t evrf_minst;
    sched_pkg::mfu_minst_t  mfu0_minst;
    sched_pkg::mfu_minst_t  mfu1_minst;
    sched_pkg::ld_minst_t   ld_minst;

    // host copy of the chain memory
    sched_pkg::minst_chain_t shadow [INST_DEPTH];
    logic [63:0]             exp_q [NUM_UNITS][$];
    int                      received [NUM_UNITS];
    int                      stall [NUM_UNITS];
    logic [NUM_UNITS-1:0]    held;
    logic [63:0]             held_data [NUM_UNITS];
    int                      ready_mode = 0;
    int                      errors = 0;
    int                      checks = 0;
    int                      tests_run = 0;
    int                      tests_bad = 0;
    int                      test_first_error = 0;

    top_sched #(
        .INST_DEPTH (INST_DEPTH),
        .QDEPTH     (QDEPTH)
    ) uut (
        .clk                (clk),
        .rst                (rst),
        .i_minst_wr_en      (minst_wr_en),
        .i_minst_wr_addr    (minst_wr_addr),
        .i_minst_wr_data    (minst_wr_data),
        .i_start            (start_pulse),
        .i_pc_start         (pc_start),
        .o_busy             (busy),
        .o_mvu_minst_valid  (mvu_valid),
        .i_mvu_minst_ready  (rdy[0]),
        .o_mvu_minst        (mvu_minst),
        .o_evrf_minst_valid (evrf_valid),
        .i_evrf_minst_ready (rdy[1]),
        .o_evrf_minst       (evrf_minst),
        .o_mfu0_minst_valid (mfu0_valid),
        .i_mfu0_minst_ready (rdy[2]),
        .o_mfu0_minst       (mfu0_minst),
        .o_mfu1_minst_valid (mfu1_valid),
        .i_mfu1_minst_ready (rdy[3]),
        .o_mfu1_minst       (mfu1_minst),
        .o_ld_minst_valid   (ld_valid),
        .i_ld_minst_ready   (rdy[4]),
        .o_ld_minst         (ld_minst)
    );

    assign vld = {ld_valid, mfu1_valid, mfu0_valid, evrf_valid, mvu_valid};
    assign chan_data[0] = 64'(mvu_minst);
    assign chan_data[1] = 64'(evrf_minst);
    assign chan_data[2] = 64'(mfu0_minst);
    assign chan_data[3] = 64'(mfu1_minst);
    assign chan_data[4] = 64'(ld_minst);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic string unit_name(input int u);
        case (u)
            0:       return "mvu";
            1:       return "evrf";
            2:       return "mfu0";
            3:       return "mfu1";
            default: return "ld";
        endcase
    endfunction

    // only a halt word carries the all-ones tag
    function automatic sched_pkg::minst_chain_t random_word(input bit halt);
        logic [191:0]            raw;
        sched_pkg::minst_chain_t w;
        raw = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
        w = raw[sched_pkg::MICW-1:0];
        if (halt) begin
            w.mvu[sched_pkg::NTAGW-1:0] = '1;
        end else if (w.mvu[sched_pkg::NTAGW-1:0] == '1) begin
            w.mvu[0] = 1'b0;
        end
        return w;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            n += exp_q[u].size();
        end
        return n;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic check_item(input int u, input logic [63:0] got);
        logic [63:0] exp;
        checks++;
        received[u]++;
        assert (exp_q[u].size() > 0) else begin
            $display("%0t: %s delivered an item that was never issued", $time, unit_name(u));
            errors++;
        end
        if (exp_q[u].size() > 0) begin
            exp = exp_q[u].pop_front();
            assert (got == exp) else report_mismatch({"o_", unit_name(u), "_minst"}, exp, got);
        end
    endtask

    // handshake monitor samples mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            held = '0;
        end else begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (held[u]) begin
                    assert (vld[u] && chan_data[u] == held_data[u]) else begin
                        $display("%0t: %s dropped or changed its item before the handshake",
                                 $time, unit_name(u));
                        errors++;
                    end
                end
                if (vld[u] && rdy[u]) begin
                    check_item(u, chan_data[u]);
                end
                held[u] = vld[u] && !rdy[u];
                held_data[u] = chan_data[u];
            end
        end
    end

    // consumers stay ready in mode 0 and toggle randomly with long stalls otherwise
    initial begin
        rdy = '0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            stall[u] = 0;
        end
        forever begin
            step();
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (ready_mode == 0) begin
                    stall[u] = 0;
                    rdy[u] = 1'b1;
                end else if (stall[u] > 0) begin
                    stall[u]--;
                    rdy[u] = 1'b0;
                end else if ($urandom % 24 == 0) begin
                    stall[u] = 8 + int'($urandom % 20);
                    rdy[u] = 1'b0;
                end else begin
                    rdy[u] = ($urandom % 3) != 0;
                end
            end
        end
    end

    task automatic set_ready_mode(input int mode);
        @(negedge clk);
        ready_mode = mode;
    endtask

    // len words from first_addr and a halt word after them
    task automatic load_chain(input int first_addr, input int len);
        for (int i = 0; i <= len; i++) begin
            step();
            minst_wr_en   = 1'b1;
            minst_wr_addr = ADDRW'(first_addr + i);
            minst_wr_data = random_word(i == len);
            shadow[first_addr + i] = minst_wr_data;
        end
        step();
        minst_wr_en = 1'b0;
    endtask

    // walk the host copy up to the halt word
    task automatic queue_expected(input int first_addr, output int n);
        int                      addr;
        sched_pkg::minst_chain_t w;
        addr = first_addr;
        n = 0;
        w = shadow[addr];
        while (w.mvu[sched_pkg::NTAGW-1:0] != '1) begin
            exp_q[0].push_back(64'(w.mvu));
            exp_q[1].push_back(64'(w.evrf));
            exp_q[2].push_back(64'(w.mfu0));
            exp_q[3].push_back(64'(w.mfu1));
            exp_q[4].push_back(64'(w.ld));
            n++;
            addr = (addr + 1) % INST_DEPTH;
            w = shadow[addr];
        end
    endtask

    task automatic run_and_check(input int first_addr, input int poke_addr);
        int n;
        int limit;
        int c;
        for (int u = 0; u < NUM_UNITS; u++) begin
            received[u] = 0;
        end
        queue_expected(first_addr, n);
        limit = n * 40 + 200;
        step();
        start_pulse = 1'b1;
        pc_start    = ADDRW'(first_addr);
        step();
        start_pulse = 1'b0;
        @(negedge clk);
        assert (busy) else report_mismatch("o_busy", 64'd1, 64'(busy));
        // a second start while busy must be ignored
        if (poke_addr >= 0) begin
            step();
            assert (busy) else begin
                $display("%0t: run ended before the second start pulse", $time);
                errors++;
            end
            start_pulse = 1'b1;
            pc_start    = ADDRW'(poke_addr);
            step();
            start_pulse = 1'b0;
        end
        c = 0;
        while (busy && c < limit) begin
            @(negedge clk);
            c++;
        end
        assert (!busy) else begin
            $display("%0t: run did not end within %0d cycles", $time, limit);
            errors++;
        end
        c = 0;
        while (pending() > 0 && c < limit) begin
            @(negedge clk);
            c++;
        end
        assert (pending() == 0) else begin
            $display("%0t: %0d issued items never reached their channels", $time, pending());
            errors++;
        end
        // room for a stray extra item to show up
        repeat (10) @(negedge clk);
        for (int u = 0; u < NUM_UNITS; u++) begin
            assert (received[u] == n) else
                report_mismatch({unit_name(u), " item count"}, 64'(n), 64'(received[u]));
            exp_q[u].delete();
        end
    endtask

    task automatic test_reset();
        for (int c = 0; c < 7; c++) begin
            step();
            @(negedge clk);
            assert (!busy) else report_mismatch("o_busy", 64'd0, 64'(busy));
            assert (vld == '0) else report_mismatch("output valids", 64'd0, 64'(vld));
        end
        step();
        rst = 1'b0;
        repeat (12) begin
            @(negedge clk);
            assert (!busy) else report_mismatch("o_busy", 64'd0, 64'(busy));
            assert (vld == '0) else report_mismatch("output valids", 64'd0, 64'(vld));
        end
    endtask

    task automatic open_test();
        test_first_error = errors;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == test_first_error) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_first_error);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        minst_wr_en   = 1'b0;
        minst_wr_addr = '0;
        minst_wr_data = '0;
        start_pulse   = 1'b0;
        pc_start      = '0;

        open_test();
        test_reset();
        close_test("reset");

        open_test();
        load_chain(0, 20);
        run_and_check(0, -1);
        close_test("free flow");

        open_test();
        load_chain(32, 40);
        set_ready_mode(1);
        run_and_check(32, -1);
        close_test("back-pressure");

        // words after the first halt must never issue
        open_test();
        load_chain(100, 10);
        load_chain(111, 9);
        run_and_check(100, -1);
        close_test("halt word");

        open_test();
        load_chain(130, 8);
        run_and_check(130, -1);
        run_and_check(134, 0);
        close_test("start offset and restart");

        $display("summary: %0d tests, %0d with errors, %0d items checked, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: simulation still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/sched_pkg.sv
rtl/minst_chain_ram.sv
rtl/minst_fifo.sv
rtl/chain_issue_ctrl.sv
rtl/top_sched.sv
verification/tb_top_sched.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_top_sched

.PHONY: check run clean

check: run
	@grep -qx 'Test passed' sim.log || (echo "simulation reported a failure"; exit 1)
	@echo "simulation ok"

run: $(SIM)
	./$(SIM) | tee sim.log

$(SIM): list.f $(shell cat list.f)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	    -f list.f --top-module tb_top_sched -j 0

clean:
	rm -rf obj_dir sim.log
